//--- run.sh
#!/bin/sh
# build the ecc_cal testbench with verilator, run it, then scan the log.

cd "$(dirname "$0")" || exit 1

BUILD_DIR=obj_dir
SIM_BIN=ecc_cal_sim
LOG=sim.log

verilator --binary --timing --assert -Wno-fatal -f sim.f \
    --top-module ecc_cal_tb --Mdir "$BUILD_DIR" -o "$SIM_BIN"
if [ $? -ne 0 ]; then
    echo "verilator build failed"
    exit 1
fi

"./$BUILD_DIR/$SIM_BIN" > "$LOG" 2>&1
sim_status=$?
cat "$LOG"
if [ $sim_status -ne 0 ]; then
    echo "simulation exited with status $sim_status"
    exit 1
fi

if grep -q "^STATUS: PASS$" "$LOG"; then
    exit 0
fi
echo "pass line not found in $LOG"
exit 1

//--- sim.f
+incdir+test
src/ecc_geom_pkg.sv
src/ecc_flag_pkg.sv
src/ecc_encoder.sv
src/ecc_check_stage.sv
src/ecc_syndrome_decoder.sv
src/ecc_correct_stage.sv
src/ecc_cal.sv
test/ecc_cal_tb.sv

//--- src/ecc_cal.sv
`timescale 1ns/1ps
`default_nettype none

module ecc_cal (
    input  logic                  clk,
    input  logic                  rst_n,
    input  ecc_geom_pkg::data_t   data_in,
    input  ecc_geom_pkg::parity_t parity_in,
    input  logic                  bypass,
    output ecc_geom_pkg::data_t   data_out,
    output ecc_geom_pkg::parity_t parity_out,
    output ecc_geom_pkg::data_t   mask,
    output logic                  sbit_err,
    output logic                  dbit_err
);

    import ecc_geom_pkg::*;

    // stage one to stage two.
    data_t   data_q;
    parity_t syndrome_q;
    logic    bypass_q;

    // ##################################################
    // check, then correct.
    // ##################################################
    ecc_check_stage u_check (
        .clk        (clk),
        .rst_n      (rst_n),
        .data_in    (data_in),
        .parity_in  (parity_in),
        .bypass     (bypass),
        .data_q     (data_q),
        .syndrome_q (syndrome_q),
        .bypass_q   (bypass_q),
        .parity_out (parity_out)
    );

    ecc_correct_stage u_correct (
        .clk        (clk),
        .rst_n      (rst_n),
        .data_q     (data_q),
        .syndrome_q (syndrome_q),
        .bypass_q   (bypass_q),
        .data_out   (data_out),
        .mask       (mask),
        .sbit_err   (sbit_err),
        .dbit_err   (dbit_err)
    );

endmodule

`default_nettype wire

//--- src/ecc_check_stage.sv
`timescale 1ns/1ps
`default_nettype none

module ecc_check_stage (
    input  logic                  clk,
    input  logic                  rst_n,
    input  ecc_geom_pkg::data_t   data_in,
    input  ecc_geom_pkg::parity_t parity_in,
    input  logic                  bypass,
    output ecc_geom_pkg::data_t   data_q,
    output ecc_geom_pkg::parity_t syndrome_q,
    output logic                  bypass_q,
    output ecc_geom_pkg::parity_t parity_out
);

    import ecc_geom_pkg::*;

    parity_t parity_c;
    parity_t parity_d1;

    ecc_encoder u_encoder (
        .data   (data_in),
        .parity (parity_c)
    );

    // ##################################################
    // stage one registers.
    // ##################################################
    always_ff @(posedge clk) begin
        if (!rst_n) begin
            data_q     <= '0;
            syndrome_q <= '0;
            bypass_q   <= 1'b0;
            parity_d1  <= '0;
        end else begin
            data_q     <= data_in;
            syndrome_q <= parity_in ^ parity_c;
            bypass_q   <= bypass;
            parity_d1  <= parity_c;
        end
    end

    // second flop so parity_out lines up with the corrected word.
    always_ff @(posedge clk) begin
        if (!rst_n) begin
            parity_out <= '0;
        end else begin
            parity_out <= parity_d1;
        end
    end

endmodule

`default_nettype wire

//--- src/ecc_correct_stage.sv
`timescale 1ns/1ps
`default_nettype none

module ecc_correct_stage (
    input  logic                  clk,
    input  logic                  rst_n,
    input  ecc_geom_pkg::data_t   data_q,
    input  ecc_geom_pkg::parity_t syndrome_q,
    input  logic                  bypass_q,
    output ecc_geom_pkg::data_t   data_out,
    output ecc_geom_pkg::data_t   mask,
    output logic                  sbit_err,
    output logic                  dbit_err
);

    import ecc_geom_pkg::*;
    import ecc_flag_pkg::*;

    data_t      mask_c;
    err_class_t err_class;
    data_t      data_fix;

    ecc_syndrome_decoder u_decoder (
        .syndrome  (syndrome_q),
        .mask      (mask_c),
        .err_class (err_class)
    );

    // raw word under bypass.
    assign data_fix = bypass_q ? data_q : (data_q ^ mask_c);

    // ##################################################
    // stage two registers.
    // ##################################################
    always_ff @(posedge clk) begin
        if (!rst_n) begin
            data_out <= '0;
            mask     <= '0;
            sbit_err <= 1'b0;
            dbit_err <= 1'b0;
        end else begin
            data_out <= data_fix;
            mask     <= mask_c;  // kept visible in bypass too.
            sbit_err <= !bypass_q && (err_class == ERR_SINGLE);
            dbit_err <= !bypass_q && (err_class == ERR_DOUBLE);
        end
    end

endmodule

`default_nettype wire

//--- src/ecc_encoder.sv
`timescale 1ns/1ps
`default_nettype none

module ecc_encoder (
    input  ecc_geom_pkg::data_t   data,
    output ecc_geom_pkg::parity_t parity
);

    import ecc_geom_pkg::*;

    // ##################################################
    // check bit fold.
    // ##################################################
    // each data bit contributes to the check bits its position selects.
    // the top bit gathers the even-weight positions so every column is odd.
    always_comb begin
        pos_t pos;
        parity = '0;
        for (int i = 0; i < DATA_WIDTH; i++) begin
            pos = data_pos(i);
            for (int k = 0; k < POS_WIDTH; k++) begin
                if (pos[k]) begin
                    parity[k] = parity[k] ^ data[i];
                end
            end
            if (~^pos) begin  // even number of ones.
                parity[OVERALL_BIT] = parity[OVERALL_BIT] ^ data[i];
            end
        end
    end

endmodule

`default_nettype wire

//--- src/ecc_flag_pkg.sv
`default_nettype none

package ecc_flag_pkg;

    // ##################################################
    // error classes and pipeline depth.
    // ##################################################
    typedef logic [1:0] err_class_t;

    localparam err_class_t ERR_NONE   = 2'b00;
    localparam err_class_t ERR_SINGLE = 2'b01;  // bit 0 drives sbit_err.
    localparam err_class_t ERR_DOUBLE = 2'b10;  // bit 1 drives dbit_err.

    // edges from input sample to outputs.
    localparam int PIPE_LATENCY = 2;

endpackage

`default_nettype wire

//--- src/ecc_geom_pkg.sv
`default_nettype none

package ecc_geom_pkg;

    // ##################################################
    // code geometry.
    // ##################################################
    localparam int DATA_WIDTH   = 105;
    localparam int PARITY_WIDTH = 8;
    localparam int POS_WIDTH    = 7;
    localparam int OVERALL_BIT  = 7;  // even-weight check bit.

    typedef logic [DATA_WIDTH-1:0]   data_t;
    typedef logic [PARITY_WIDTH-1:0] parity_t;  // check bits or syndrome.
    typedef logic [POS_WIDTH-1:0]    pos_t;

    // codeword position of data bit idx.
    // skips 0, 1 and every power of two, so bit 0 lands on 3.
    function automatic pos_t data_pos(input int unsigned idx);
        int unsigned cnt;
        int unsigned p;
        pos_t        result;
        cnt    = 0;
        result = '0;
        for (p = 3; p < (1 << POS_WIDTH); p++) begin
            if ((p & (p - 1)) != 0) begin
                if (cnt == idx) begin
                    result = pos_t'(p);
                end
                cnt++;
            end
        end
        return result;
    endfunction

endpackage

`default_nettype wire

//--- src/ecc_syndrome_decoder.sv
`timescale 1ns/1ps
`default_nettype none

module ecc_syndrome_decoder (
    input  ecc_geom_pkg::parity_t    syndrome,
    output ecc_geom_pkg::data_t      mask,
    output ecc_flag_pkg::err_class_t err_class
);

    import ecc_geom_pkg::*;
    import ecc_flag_pkg::*;

    // ##################################################
    // column match.
    // ##################################################
    // a data column is its position plus the even-weight bit on top.
    always_comb begin
        pos_t    pos;
        parity_t col;
        mask = '0;
        for (int i = 0; i < DATA_WIDTH; i++) begin
            pos = data_pos(i);
            col = '0;
            col[POS_WIDTH-1:0] = pos;
            col[OVERALL_BIT]   = ~^pos;
            if (syndrome == col) begin
                mask[i] = 1'b1;
            end
        end
    end

    // ##################################################
    // error class.
    // ##################################################
    always_comb begin
        if (syndrome == '0) begin
            err_class = ERR_NONE;
        end else if ($onehot(syndrome)) begin
            err_class = ERR_SINGLE;  // check bit flipped, data intact.
        end else if (|mask) begin
            err_class = ERR_SINGLE;
        end else begin
            err_class = ERR_DOUBLE;  // even weight, not correctable.
        end
    end

endmodule

`default_nettype wire

//--- test/ecc_ref_model.svh
`ifndef ECC_REF_MODEL_SVH
`define ECC_REF_MODEL_SVH

// ##################################################
// reference SECDED code, built from the position rule.
// ##################################################
// low seven bits hold the position, bit 7 marks an even-weight position.
parity_t code_columns [DATA_WIDTH];

task automatic build_columns();
    int unsigned p;
    int          n;
    n = 0;
    for (p = 3; n < DATA_WIDTH; p++) begin
        if ($countones(p) != 1) begin  // skip powers of two.
            code_columns[n] = {(($countones(p) % 2) == 0), pos_t'(p)};
            n++;
        end
    end
endtask

function automatic parity_t encode_word(input data_t d);
    parity_t chk;
    chk = '0;
    for (int i = 0; i < DATA_WIDTH; i++) begin
        if (d[i]) begin
            chk = chk ^ code_columns[i];
        end
    end
    return chk;
endfunction

function automatic void decode_syndrome(input parity_t syn, output data_t msk,
                                        output logic sbit, output logic dbit);
    msk  = '0;
    sbit = 1'b0;
    dbit = 1'b0;
    if (syn != '0) begin
        if ($countones(syn) == 1) begin
            sbit = 1'b1;  // check bit only.
        end else begin
            for (int i = 0; i < DATA_WIDTH; i++) begin
                if (syn == code_columns[i]) begin
                    msk[i] = 1'b1;
                end
            end
            if (msk != '0) begin
                sbit = 1'b1;
            end else begin
                dbit = 1'b1;
            end
        end
    end
endfunction

function automatic void expected_outputs(input data_t din, input parity_t pin, input logic byp,
                                         output data_t dout, output parity_t pout,
                                         output data_t msk, output logic sbit,
                                         output logic dbit);
    logic s;
    logic d;
    pout = encode_word(din);
    decode_syndrome(pin ^ pout, msk, s, d);
    dout = byp ? din : (din ^ msk);
    sbit = s & ~byp;  // flags cleared by bypass.
    dbit = d & ~byp;
endfunction

`endif

//--- test/ecc_cal_tb.sv
`timescale 1ns/1ps
`default_nettype none

module ecc_cal_tb;

    import ecc_geom_pkg::*;
    import ecc_flag_pkg::*;

    localparam int CLK_PERIOD    = 100;
    localparam int RESET_CYCLES  = 8;
    localparam int DRAIN_TIMEOUT = 20;
    localparam int CODE_BITS     = DATA_WIDTH + PARITY_WIDTH;
    localparam int N_WORDS       = 40;

    localparam int KIND_CLEAN  = 0;
    localparam int KIND_DATA   = 1;
    localparam int KIND_CHECK  = 2;
    localparam int KIND_DOUBLE = 3;

    typedef struct packed {
        data_t   data_out;
        parity_t parity_out;
        data_t   mask;
        logic    sbit_err;
        logic    dbit_err;
        int      edge_no;  // edge count when driven.
    } exp_entry_t;

    logic    clk;
    logic    rst_n;
    data_t   data_in;
    parity_t parity_in;
    logic    bypass;
    data_t   data_out;
    parity_t parity_out;
    data_t   mask;
    logic    sbit_err;
    logic    dbit_err;

    exp_entry_t  exp_q[$];
    logic [31:0] lcg_state = 32'd12439;
    int          edge_cnt  = 0;
    int          post_rst  = 0;
    int          check_cnt = 0;
    int          err_cnt   = 0;
    int          word_cnt  = 0;

    `include "ecc_ref_model.svh"

    ecc_cal DUT (
        .clk        (clk),
        .rst_n      (rst_n),
        .data_in    (data_in),
        .parity_in  (parity_in),
        .bypass     (bypass),
        .data_out   (data_out),
        .parity_out (parity_out),
        .mask       (mask),
        .sbit_err   (sbit_err),
        .dbit_err   (dbit_err)
    );

    initial clk = 1'b0;
    always #(CLK_PERIOD / 2) clk = ~clk;

    // ##################################################
    // random stimulus.
    // ##################################################
    function automatic logic [31:0] lcg_next();
        lcg_state = lcg_state * 32'd1103515245 + 32'd12345;
        return lcg_state;
    endfunction

    function automatic int unsigned rand_range(input int unsigned n);
        return (lcg_next() >> 8) % n;
    endfunction

    function automatic data_t rand_data();
        logic [127:0] raw;
        logic [31:0]  t;
        raw = '0;
        for (int i = 0; i < 8; i++) begin
            t   = lcg_next();
            raw = {raw[111:0], t[31:16]};  // upper bits only.
        end
        return raw[DATA_WIDTH-1:0];
    endfunction

    task automatic flip_bit(input int unsigned idx, inout data_t d, inout parity_t p);
        if (idx < DATA_WIDTH) begin
            d[idx] = ~d[idx];
        end else begin
            p[idx - DATA_WIDTH] = ~p[idx - DATA_WIDTH];
        end
    endtask

    task automatic make_word(input int kind, output data_t d, output parity_t p);
        int unsigned a;
        int unsigned b;
        d = rand_data();
        p = encode_word(d);
        a = rand_range(CODE_BITS);
        b = (a + 1 + rand_range(CODE_BITS - 1)) % CODE_BITS;  // never equal to a.
        case (kind)
            KIND_DATA:   flip_bit(rand_range(DATA_WIDTH), d, p);
            KIND_CHECK:  flip_bit(DATA_WIDTH + rand_range(PARITY_WIDTH), d, p);
            KIND_DOUBLE: begin
                flip_bit(a, d, p);
                flip_bit(b, d, p);
            end
            default: ;
        endcase
    endtask

    task automatic drive_word(input data_t d, input parity_t p, input logic byp);
        exp_entry_t e;
        data_t      dout;
        parity_t    pout;
        data_t      msk;
        logic       s;
        logic       db;
        @(negedge clk);
        data_in   = d;
        parity_in = p;
        bypass    = byp;
        expected_outputs(d, p, byp, dout, pout, msk, s, db);
        e.data_out   = dout;
        e.parity_out = pout;
        e.mask       = msk;
        e.sbit_err   = s;
        e.dbit_err   = db;
        e.edge_no    = edge_cnt;
        exp_q.push_back(e);
        word_cnt++;
    endtask

    task automatic run_words(input int n, input int kind, input logic byp);
        data_t   d;
        parity_t p;
        for (int i = 0; i < n; i++) begin
            make_word(kind, d, p);
            drive_word(d, p, byp);
        end
    endtask

    // back to back, error kind and bypass both random.
    task automatic run_mixed(input int n);
        data_t   d;
        parity_t p;
        for (int i = 0; i < n; i++) begin
            make_word(int'(rand_range(4)), d, p);
            drive_word(d, p, rand_range(2) == 1);
        end
    endtask

    // ##################################################
    // checks.
    // ##################################################
    task automatic check_value(input string name, input logic [127:0] expv,
                               input logic [127:0] actv);
        check_cnt++;
        assert (actv === expv) else begin
            err_cnt++;
            $display("ERR %s exp=%h act=%h at %0t", name, expv, actv, $time);
        end
    endtask

    task automatic check_zero();
        check_value("data_out", 128'(0), 128'(data_out));
        check_value("parity_out", 128'(0), 128'(parity_out));
        check_value("mask", 128'(0), 128'(mask));
        check_value("sbit_err", 128'(0), 128'(sbit_err));
        check_value("dbit_err", 128'(0), 128'(dbit_err));
    endtask

    task automatic compare_entry(input exp_entry_t e);
        check_value("data_out", 128'(e.data_out), 128'(data_out));
        check_value("parity_out", 128'(e.parity_out), 128'(parity_out));
        check_value("mask", 128'(e.mask), 128'(mask));
        check_value("sbit_err", 128'(e.sbit_err), 128'(sbit_err));
        check_value("dbit_err", 128'(e.dbit_err), 128'(dbit_err));
    endtask

    task automatic report_and_finish();
        $display("checks=%0d words=%0d errors=%0d", check_cnt, word_cnt, err_cnt);
        if (err_cnt == 0) begin
            $display("STATUS: PASS");
        end else begin
            $display("STATUS: FAIL");
        end
        $finish;
    endtask

    // outputs settle well before a quarter period after the edge.
    initial begin : compare_proc
        exp_entry_t e;
        forever begin
            @(posedge clk);
            edge_cnt++;
            #(CLK_PERIOD / 4);
            if (!rst_n) begin
                post_rst = 0;
                check_zero();
            end else begin
                post_rst++;
                if (exp_q.size() != 0 && exp_q[0].edge_no + PIPE_LATENCY == edge_cnt) begin
                    e = exp_q.pop_front();
                    compare_entry(e);
                end else if (post_rst <= PIPE_LATENCY) begin
                    check_zero();  // pipeline still flushed by reset.
                end
            end
        end
    end

    // ##################################################
    // test sequence.
    // ##################################################
    initial begin : stimulus
        int wait_cnt;
        rst_n     = 1'b0;
        data_in   = '0;
        parity_in = '0;
        bypass    = 1'b0;
        build_columns();
        // junk on the inputs must not leak through reset.
        for (int i = 0; i < RESET_CYCLES - 1; i++) begin
            @(negedge clk);
            data_in   = rand_data();
            parity_in = parity_t'(lcg_next() >> 16);
            bypass    = rand_range(2) == 1;
        end
        @(negedge clk);
        rst_n     = 1'b1;
        data_in   = '0;
        parity_in = '0;
        bypass    = 1'b0;

        run_words(N_WORDS, KIND_CLEAN, 1'b0);
        run_words(N_WORDS, KIND_DATA, 1'b0);
        run_words(N_WORDS, KIND_CHECK, 1'b0);
        run_words(N_WORDS, KIND_DOUBLE, 1'b0);
        run_words(N_WORDS / 2, KIND_DATA, 1'b1);
        run_words(N_WORDS / 2, KIND_DOUBLE, 1'b1);
        run_mixed(2 * N_WORDS);

        for (wait_cnt = 0; wait_cnt < DRAIN_TIMEOUT && exp_q.size() != 0; wait_cnt++) begin
            @(negedge clk);
        end
        if (exp_q.size() != 0) begin
            $display("timeout: %0d expected results never reached the outputs", exp_q.size());
            err_cnt++;
        end
        report_and_finish();
    end

endmodule

`default_nettype wire
